// ==== sim.f ====
design/game_pkg.sv
design/frame_control.sv
design/obstacle_field.sv
design/hero_motion.sv
design/pixel_painter.sv
design/vga_game_top.sv
dv/tb_clock.sv
dv/vga_game_assertions.sv
dv/vga_game_tb.sv

// ==== Bender.yml ====
package:
  name: vga_game

sources:
  - design/game_pkg.sv
  - design/frame_control.sv
  - design/obstacle_field.sv
  - design/hero_motion.sv
  - design/pixel_painter.sv
  - design/vga_game_top.sv
  - target: simulation
    files:
      - dv/tb_clock.sv
      - dv/vga_game_assertions.sv
      - dv/vga_game_tb.sv

// ==== dv/vga_game_tb.sv ====
`timescale 1ns/100ps

module vga_game_tb;

	// run length in frame steps
	// slow game ends on event 256 plus one spare step
	localparam int RUN_SLOW = 257;
	localparam int RUN_FAST = 104;
	localparam int PAUSE_FRAMES = 8;
	localparam int AFTER_END = 4;
	// frame pixel plus five probes
	localparam int STEP_CYCLES = 6;
	localparam int TIMEOUT_CYCLES = (RUN_SLOW + RUN_FAST + 2 * (PAUSE_FRAMES + AFTER_END))
		* STEP_CYCLES + 200;

	logic clk_50m;
	logic rst;
	logic pause;
	logic [1:0] sw;
	game_pkg::coord_x_t vector_x;
	game_pkg::coord_y_t vector_y;
	game_pkg::hero_shift_t rel_xx;
	logic endgame;
	logic [2:0] vga_red;
	logic [2:0] vga_green;
	logic [1:0] vga_blue;
	int cycle_count = 0;
	// unpaused frame events and step size
	// used only to aim probes at the bar
	int moves;
	int step;

	tb_clock u_clock (.clk_50m(clk_50m));

	vga_game_top UUT (.clk_50m(clk_50m), .rst(rst), .pause(pause), .sw(sw),
		.vector_x(vector_x), .vector_y(vector_y), .rel_xx(rel_xx), .endgame(endgame),
		.vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue));

	task automatic move_scan(input game_pkg::coord_x_t x, input game_pkg::coord_y_t y);
		@(posedge clk_50m);
		vector_x <= x;
		vector_y <= y;
	endtask

	// --------------------------------------------------
	// pixel probes of one cycle each
	// --------------------------------------------------
	task automatic probe_pixels();
		int bar_row;
		bar_row = 589 - step * moves;
		if (bar_row < 0)
			bar_row = 0;
		// border on either side
		move_scan(($urandom % 2) ? game_pkg::coord_x_t'($urandom_range(80))
			: game_pkg::coord_x_t'($urandom_range(799, 720)),
			game_pkg::coord_y_t'($urandom_range(599)));
		// stripe columns
		move_scan(($urandom % 2) ? game_pkg::coord_x_t'($urandom_range(99, 81))
			: game_pkg::coord_x_t'($urandom_range(719, 701)),
			game_pkg::coord_y_t'($urandom_range(599)));
		// off screen to the right or below
		if ($urandom % 2)
			move_scan(game_pkg::coord_x_t'($urandom_range(2047, 800)),
				game_pkg::coord_y_t'($urandom_range(1023)));
		else
			move_scan(game_pkg::coord_x_t'($urandom_range(799)),
				game_pkg::coord_y_t'($urandom_range(1023, 600)));
		// any row of the probe column
		move_scan(11'd300, game_pkg::coord_y_t'($urandom_range(599)));
		// middle of the bar where the state is already updated
		move_scan(11'd300, game_pkg::coord_y_t'(bar_row));
	endtask

	task automatic frame_step();
		move_scan(game_pkg::H_LAST, game_pkg::V_LAST);
		if (!pause)
			moves++;
		probe_pixels();
	endtask

	task automatic apply_reset(input logic [1:0] level);
		@(posedge clk_50m);
		rst <= 1'b0;
		sw <= level;
		pause <= 1'b0;
		repeat (3) @(posedge clk_50m);
		rst <= 1'b1;
	endtask

	// one game from reset to a few frames past the end latch
	task automatic run_game(input logic [1:0] level, input int lead_in);
		apply_reset(level);
		step = game_pkg::SPEED_TABLE[level];
		moves = 0;
		repeat (lead_in) frame_step();
		@(posedge clk_50m);
		pause <= 1'b1;
		repeat (PAUSE_FRAMES) frame_step();
		@(posedge clk_50m);
		pause <= 1'b0;
		@(negedge clk_50m);
		while (!endgame)
		begin
			frame_step();
			@(negedge clk_50m);
		end
		repeat (AFTER_END) frame_step();
	endtask

	initial
	begin
		rst = 1'b0;
		pause = 1'b0;
		sw = 2'b00;
		vector_x = '0;
		vector_y = '0;
		rel_xx = -12'sd400;
		void'($urandom(75));
		run_game(2'b00, 20);
		run_game(2'b11, 5);
		repeat (2) @(posedge clk_50m);
		if (UUT.u_assertions.fail_count != 0)
		begin
			$display("TB FAILED");
			$fatal(1, "assertion errors were reported");
		end
		else
		begin
			$display("TB PASSED");
			$finish;
		end
	end

	// stop at the first assertion error
	always @(UUT.u_assertions.fail_count)
	begin
		if (UUT.u_assertions.fail_count != 0)
		begin
			$display("TB FAILED");
			$fatal(1, "stopped at the first assertion error");
		end
	end

	always @(posedge clk_50m)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("TB FAILED");
			$fatal(1, "timeout, the run did not finish within %0d cycles", cycle_count);
		end
	end

endmodule

// ==== dv/vga_game_assertions.sv ====
`timescale 1ns/100ps

module vga_game_assertions
(
	input logic                  clk_50m,
	input logic                  rst,
	input logic                  pause,
	input logic [1:0]            sw,
	input game_pkg::coord_x_t    vector_x,
	input game_pkg::coord_y_t    vector_y,
	input game_pkg::hero_shift_t rel_xx,
	input logic                  endgame,
	input logic [2:0]            vga_red,
	input logic [2:0]            vga_green,
	input logic [1:0]            vga_blue
);

	logic [7:0] pix;
	logic frame_event;
	logic advance_d;
	logic [1:0] sw_d;
	int pos_m;
	int hero_m;
	logic end_m;
	logic visible;
	logic border_col;
	logic stripe_col;
	logic lit_row;
	logic interior;
	logic probe_col;
	logic [7:0] scroll_exp;
	int row_mod;
	int fail_count = 0;

	assign pix = {vga_red, vga_green, vga_blue};
	// last visible pixel, unpaused
	assign frame_event = (vector_x == game_pkg::H_LAST) && (vector_y == game_pkg::V_LAST) && !pause;

	// --------------------------------------------------
	// frame model, one cycle behind the event like the DUT
	// --------------------------------------------------
	always_ff @(posedge clk_50m or negedge rst)
	begin
		if (!rst)
		begin
			advance_d <= 1'b0;
			sw_d <= 2'b00;
			pos_m <= 0;
			hero_m <= int'(game_pkg::HERO_START);
			end_m <= 1'b0;
		end
		else
		begin
			advance_d <= frame_event;
			sw_d <= sw;
			// latch a cycle after the hero reaches the end row
			end_m <= end_m || (hero_m >= int'(game_pkg::END_ROW));
			if (advance_d)
			begin
				if (int'(game_pkg::BASE_Y) - pos_m == int'(game_pkg::WRAP_GAP_TABLE[sw_d]))
					pos_m <= 0;
				else
					pos_m <= pos_m + int'(game_pkg::SPEED_TABLE[sw_d]);
				// hero frozen after the end
				if (!end_m && (hero_m + int'(game_pkg::OBST_HEIGHT) <= int'(game_pkg::V_LAST)))
					hero_m <= hero_m + int'(game_pkg::SPEED_TABLE[sw_d]);
				else if (!end_m)
					hero_m <= int'(game_pkg::HERO_START);
			end
		end
	end

	// screen regions
	assign visible = (vector_x <= 11'd799) && (vector_y <= 10'd599);
	assign border_col = (vector_x <= 11'd80) || (vector_x >= 11'd720);
	assign stripe_col = ((vector_x > 11'd80) && (vector_x < 11'd100))
		|| ((vector_x > 11'd700) && (vector_x < 11'd720));
	assign row_mod = int'(vector_y) % 100;
	// multiples of 100 above row 0 are gaps
	assign lit_row = (row_mod < 80) && !((row_mod == 0) && (vector_y != '0));
	assign interior = visible && !border_col && !(stripe_col && lit_row);
	// hero parked in the right border, bars only at this column
	assign probe_col = (vector_x == 11'd300) && (rel_xx == -12'sd400);
	assign scroll_exp = ((int'(vector_y) > 579 - pos_m) && (int'(vector_y) < 599 - pos_m))
		? game_pkg::COLOR_OBST : game_pkg::COLOR_BG;

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	a_blank: assert property (@(posedge clk_50m) disable iff (!rst)
		!visible |-> pix == game_pkg::COLOR_BLANK)
	else
	begin
		$error("[FAIL] pixel = %h, expected %h", $sampled(pix), game_pkg::COLOR_BLANK);
		fail_count = fail_count + 1;
	end

	a_border: assert property (@(posedge clk_50m) disable iff (!rst)
		visible && border_col |-> pix == game_pkg::COLOR_BORDER)
	else
	begin
		$error("[FAIL] pixel = %h, expected %h", $sampled(pix), game_pkg::COLOR_BORDER);
		fail_count = fail_count + 1;
	end

	a_stripe: assert property (@(posedge clk_50m) disable iff (!rst)
		visible && stripe_col && lit_row |-> pix == game_pkg::COLOR_STRIPE)
	else
	begin
		$error("[FAIL] pixel = %h, expected %h", $sampled(pix), game_pkg::COLOR_STRIPE);
		fail_count = fail_count + 1;
	end

	a_end_screen: assert property (@(posedge clk_50m) disable iff (!rst)
		interior && end_m |-> pix == game_pkg::COLOR_END)
	else
	begin
		$error("[FAIL] pixel = %h, expected %h", $sampled(pix), game_pkg::COLOR_END);
		fail_count = fail_count + 1;
	end

	a_scroll: assert property (@(posedge clk_50m) disable iff (!rst)
		interior && !end_m && probe_col |-> pix == scroll_exp)
	else
	begin
		$error("[FAIL] pixel = %h, expected %h", $sampled(pix), $sampled(scroll_exp));
		fail_count = fail_count + 1;
	end

	a_endgame: assert property (@(posedge clk_50m) disable iff (!rst) endgame == end_m)
	else
	begin
		$error("[FAIL] endgame = %h, expected %h", $sampled(endgame), $sampled(end_m));
		fail_count = fail_count + 1;
	end

	a_end_hold: assert property (@(posedge clk_50m) disable iff (!rst) endgame |=> endgame)
	else
	begin
		$error("endgame dropped while reset was not asserted");
		fail_count = fail_count + 1;
	end

endmodule

bind vga_game_top vga_game_assertions u_assertions (.clk_50m(clk_50m), .rst(rst),
	.pause(pause), .sw(sw), .vector_x(vector_x), .vector_y(vector_y), .rel_xx(rel_xx),
	.endgame(endgame), .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue));

// ==== dv/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock
(
	output logic clk_50m
);

	// 50 MHz, 20 ns period
	localparam real HALF_PERIOD = 10.0;

	initial
	begin
		clk_50m = 1'b0;
		forever
		begin
			#HALF_PERIOD clk_50m = ~clk_50m;
		end
	end

endmodule

// ==== design/vga_game_top.sv ====
`timescale 1ns/100ps

module vga_game_top
(
	input  logic                  clk_50m,
	input  logic                  rst,
	input  logic                  pause,
	input  logic [1:0]            sw,
	input  game_pkg::coord_x_t    vector_x,
	input  game_pkg::coord_y_t    vector_y,
	input  game_pkg::hero_shift_t rel_xx,
	output logic                  endgame,
	output logic [2:0]            vga_red,
	output logic [2:0]            vga_green,
	output logic [1:0]            vga_blue
);

	logic frame_advance;
	logic [game_pkg::SPEED_W-1:0] speed;
	logic [game_pkg::GAP_W-1:0] wrap_gap;
	game_pkg::pos_t obst_pos [5];
	game_pkg::pos_t hero_y;
	game_pkg::pixel_u pixel;

	// --------------------------------------------------
	// game state
	// --------------------------------------------------
	frame_control u_frame_control (.clk_50m(clk_50m), .rst(rst), .pause(pause), .sw(sw),
		.vector_x(vector_x), .vector_y(vector_y), .frame_advance(frame_advance),
		.speed(speed), .wrap_gap(wrap_gap));
	obstacle_field u_obstacle_field (.clk_50m(clk_50m), .rst(rst),
		.frame_advance(frame_advance), .speed(speed), .wrap_gap(wrap_gap), .obst_pos(obst_pos));
	hero_motion u_hero_motion (.clk_50m(clk_50m), .rst(rst), .frame_advance(frame_advance),
		.speed(speed), .hero_y(hero_y), .endgame(endgame));

	// --------------------------------------------------
	// pixel out
	// --------------------------------------------------
	pixel_painter u_pixel_painter (.vector_x(vector_x), .vector_y(vector_y), .rel_xx(rel_xx),
		.obst_pos(obst_pos), .hero_y(hero_y), .endgame(endgame), .pixel(pixel));

	// channel split of the rgb332 word
	assign vga_red = pixel.rgb.red;
	assign vga_green = pixel.rgb.green;
	assign vga_blue = pixel.rgb.blue;

endmodule

// ==== design/pixel_painter.sv ====
`timescale 1ns/100ps

module pixel_painter
(
	input  game_pkg::coord_x_t    vector_x,
	input  game_pkg::coord_y_t    vector_y,
	input  game_pkg::hero_shift_t rel_xx,
	input  game_pkg::pos_t        obst_pos [5],
	input  game_pkg::pos_t        hero_y,
	input  logic                  endgame,
	output game_pkg::pixel_u      pixel
);

	logic blank;
	logic border;
	logic stripe_col;
	logic stripe_row;
	game_pkg::coord_y_t row_mod;
	logic [4:0] obst_hit;
	logic obst_any;
	// scan column shifted by the hero offset, signed
	logic signed [12:0] hero_col;
	logic [10:0] hero_low;
	logic hero_hit;

	// --------------------------------------------------
	// frame, border and side stripes
	// --------------------------------------------------
	assign blank = (vector_x > game_pkg::H_LAST) || (vector_y > game_pkg::V_LAST);
	assign border = (vector_x <= game_pkg::BORDER_LEFT) || (vector_x >= game_pkg::BORDER_RIGHT);
	assign stripe_col = ((vector_x > game_pkg::BORDER_LEFT) && (vector_x < game_pkg::STRIPE_LEFT_END))
		|| ((vector_x > game_pkg::STRIPE_RIGHT_START) && (vector_x < game_pkg::BORDER_RIGHT));
	assign row_mod = vector_y % game_pkg::STRIPE_PERIOD;
	// rows 100, 200 ... are gaps, row 0 is lit
	assign stripe_row = (row_mod < game_pkg::STRIPE_LEN) && !((row_mod == '0) && (vector_y != '0));

	// --------------------------------------------------
	// obstacle bars
	// --------------------------------------------------
	for (genvar k = 0; k < 5; k++)
	begin : g_obst
		logic [11:0] row_sum;
		logic [11:0] col_lhs;
		logic [11:0] col_ofs;

		// compare y + pos against the fixed rows, no negatives
		assign row_sum = {2'b00, vector_y} + {2'b00, obst_pos[k]};
		// bar 5 slides left, bar 1 slides right
		assign col_lhs = {1'b0, vector_x} + ((k == 4) ? {2'b00, obst_pos[k]} : 12'd0);
		assign col_ofs = (k == 0) ? {2'b00, obst_pos[k]} : 12'd0;
		assign obst_hit[k] = (col_lhs > ({1'b0, game_pkg::OBST_X1[k]} + col_ofs))
			&& (col_lhs < ({1'b0, game_pkg::OBST_X2[k]} + col_ofs))
			&& (row_sum > {2'b00, game_pkg::BASE_Y})
			&& (row_sum < ({2'b00, game_pkg::BASE_Y} + {2'b00, game_pkg::OBST_HEIGHT}));
	end

	assign obst_any = |obst_hit;

	// hero block, edges inclusive in x
	assign hero_col = $signed({2'b00, vector_x}) + rel_xx;
	assign hero_low = {1'b0, hero_y} + {1'b0, game_pkg::HERO_HEIGHT};
	assign hero_hit = (hero_col >= game_pkg::HERO_X1) && (hero_col <= game_pkg::HERO_X2)
		&& (vector_y >= hero_y) && ({1'b0, vector_y} < hero_low);

	// --------------------------------------------------
	// priority select
	// --------------------------------------------------
	always_comb
	begin
		if (blank)
			pixel.raw = game_pkg::COLOR_BLANK;
		else if (border)
			pixel.raw = game_pkg::COLOR_BORDER;
		else if (stripe_col && stripe_row)
			pixel.raw = game_pkg::COLOR_STRIPE;
		// end screen covers the whole interior
		else if (endgame)
			pixel.raw = game_pkg::COLOR_END;
		else if (obst_any)
			pixel.raw = game_pkg::COLOR_OBST;
		else if (hero_hit)
			pixel.raw = game_pkg::COLOR_HERO;
		else
			pixel.raw = game_pkg::COLOR_BG;
	end

endmodule

// ==== design/hero_motion.sv ====
`timescale 1ns/100ps

module hero_motion
(
	input  logic                         clk_50m,
	input  logic                         rst,
	input  logic                         frame_advance,
	input  logic [game_pkg::SPEED_W-1:0] speed,
	output game_pkg::pos_t               hero_y,
	output logic                         endgame
);

	// lower edge check, one bit wider than pos_t
	logic [10:0] hero_low;
	logic on_screen;
	logic reached_end;

	assign hero_low = {1'b0, hero_y} + {1'b0, game_pkg::OBST_HEIGHT};
	assign on_screen = hero_low <= {1'b0, game_pkg::V_LAST};
	assign reached_end = hero_y >= game_pkg::END_ROW;

	// --------------------------------------------------
	// fall, one step per frame
	// --------------------------------------------------
	always_ff @(posedge clk_50m or negedge rst)
	begin
		if (!rst)
			hero_y <= game_pkg::HERO_START;
		// frozen once the game is over
		else if (frame_advance && !endgame)
		begin
			if (on_screen)
				hero_y <= hero_y + speed;
			else
				hero_y <= game_pkg::HERO_START;
		end
	end

	// end latch, held until reset
	always_ff @(posedge clk_50m or negedge rst)
	begin
		if (!rst)
			endgame <= 1'b0;
		else if (reached_end)
			endgame <= 1'b1;
	end

endmodule

// ==== design/obstacle_field.sv ====
`timescale 1ns/100ps

module obstacle_field
(
	input  logic                         clk_50m,
	input  logic                         rst,
	input  logic                         frame_advance,
	input  logic [game_pkg::SPEED_W-1:0] speed,
	input  logic [game_pkg::GAP_W-1:0]   wrap_gap,
	output game_pkg::pos_t               obst_pos [5]
);

	// rows left between each bar and its start row
	game_pkg::pos_t climb [5];
	// bar has reached the top gap
	logic [4:0] wrap;

	// --------------------------------------------------
	// wrap detect
	// --------------------------------------------------
	always_comb
	begin
		for (int k = 0; k < 5; k++)
		begin
			climb[k] = game_pkg::BASE_Y - obst_pos[k];
			wrap[k] = (climb[k] == game_pkg::pos_t'(wrap_gap));
		end
	end

	// --------------------------------------------------
	// scroll counters
	// --------------------------------------------------
	// all five bars always enabled
	// same step for each, only the x offset differs on screen
	always_ff @(posedge clk_50m or negedge rst)
	begin
		if (!rst)
		begin
			for (int k = 0; k < 5; k++)
			begin
				obst_pos[k] <= '0;
			end
		end
		else if (frame_advance)
		begin
			for (int k = 0; k < 5; k++)
			begin
				// back to the start row near the top
				if (wrap[k])
				begin
					obst_pos[k] <= '0;
				end
				else
				begin
					// one step up per frame
					obst_pos[k] <= obst_pos[k] + speed;
				end
			end
		end
	end

endmodule

// ==== design/frame_control.sv ====
`timescale 1ns/100ps

module frame_control
(
	input  logic                         clk_50m,
	input  logic                         rst,
	input  logic                         pause,
	input  logic [1:0]                   sw,
	input  game_pkg::coord_x_t           vector_x,
	input  game_pkg::coord_y_t           vector_y,
	output logic                         frame_advance,
	output logic [game_pkg::SPEED_W-1:0] speed,
	output logic [game_pkg::GAP_W-1:0]   wrap_gap
);

	// last visible pixel of the frame
	logic last_pixel;

	assign last_pixel = (vector_x == game_pkg::H_LAST) && (vector_y == game_pkg::V_LAST);

	// --------------------------------------------------
	// one pulse per frame, none while paused
	// --------------------------------------------------
	always_ff @(posedge clk_50m or negedge rst)
	begin
		if (!rst)
		begin
			frame_advance <= 1'b0;
			speed <= game_pkg::SPEED_TABLE[0];
			wrap_gap <= game_pkg::WRAP_GAP_TABLE[0];
		end
		else
		begin
			frame_advance <= last_pixel && !pause;
			// difficulty lookup, follows sw a cycle late
			speed <= game_pkg::SPEED_TABLE[sw];
			wrap_gap <= game_pkg::WRAP_GAP_TABLE[sw];
		end
	end

endmodule

// ==== design/game_pkg.sv ====
package game_pkg;

	// --------------------------------------------------
	// scan and offset types
	// --------------------------------------------------
	typedef logic [10:0] coord_x_t;
	typedef logic [9:0] coord_y_t;
	typedef logic [9:0] pos_t;
	// negative moves the hero right on screen
	typedef logic signed [11:0] hero_shift_t;

	// rgb332 word, painted as a byte, driven out per channel
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [2:0] red;
			logic [2:0] green;
			logic [1:0] blue;
		} rgb;
	} pixel_u;

	// --------------------------------------------------
	// screen geometry
	// --------------------------------------------------
	localparam coord_x_t H_LAST = 11'd799;
	localparam coord_y_t V_LAST = 10'd599;
	localparam coord_x_t BORDER_LEFT = 11'd80;
	localparam coord_x_t BORDER_RIGHT = 11'd720;
	localparam coord_x_t STRIPE_LEFT_END = 11'd100;
	localparam coord_x_t STRIPE_RIGHT_START = 11'd700;
	localparam coord_y_t STRIPE_PERIOD = 10'd100;
	localparam coord_y_t STRIPE_LEN = 10'd80;

	// obstacles, one slot per bar
	localparam pos_t BASE_Y = 10'd579;
	localparam pos_t OBST_HEIGHT = 10'd20;
	localparam coord_x_t OBST_X1 [5] = '{11'd100, 11'd200, 11'd300, 11'd450, 11'd500};
	localparam coord_x_t OBST_X2 [5] = '{11'd300, 11'd400, 11'd500, 11'd650, 11'd700};

	// hero block
	localparam hero_shift_t HERO_X1 = 12'sd375;
	localparam hero_shift_t HERO_X2 = 12'sd425;
	localparam pos_t HERO_HEIGHT = 10'd50;
	localparam pos_t HERO_START = 10'd8;
	localparam pos_t END_ROW = 10'd520;

	// colours, rgb332
	localparam logic [7:0] COLOR_BORDER = 8'h8B;
	localparam logic [7:0] COLOR_STRIPE = 8'h1A;
	localparam logic [7:0] COLOR_OBST = 8'h1C;
	localparam logic [7:0] COLOR_BG = 8'hFF;
	localparam logic [7:0] COLOR_END = 8'hDC;
	localparam logic [7:0] COLOR_BLANK = 8'h00;
	localparam logic [7:0] COLOR_HERO = 8'hE0;

	// difficulty, indexed by sw
	localparam int SPEED_W = 3;
	localparam int GAP_W = 4;
	localparam logic [SPEED_W-1:0] SPEED_TABLE [4] = '{3'd2, 3'd3, 3'd4, 3'd5};
	localparam logic [GAP_W-1:0] WRAP_GAP_TABLE [4] = '{4'd3, 4'd3, 4'd7, 4'd9};

endpackage
